// ==== source/excPkg.sv ====
`default_nettype none

package excPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction encodings
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [5:0] {
        OpSpecial = 6'b000000,
        OpRegimm  = 6'b000001,
        OpJ       = 6'b000010,
        OpJal     = 6'b000011,
        OpBeq     = 6'b000100,
        OpBne     = 6'b000101,
        OpBlez    = 6'b000110,
        OpBgtz    = 6'b000111,
        OpAddi    = 6'b001000,
        OpAddiu   = 6'b001001,
        OpSlti    = 6'b001010,
        OpSltiu   = 6'b001011,
        OpAndi    = 6'b001100,
        OpOri     = 6'b001101,
        OpXori    = 6'b001110,
        OpLui     = 6'b001111,
        OpCop0    = 6'b010000,
        OpLb      = 6'b100000,
        OpLh      = 6'b100001,
        OpLw      = 6'b100011,
        OpLbu     = 6'b100100,
        OpLhu     = 6'b100101,
        OpSb      = 6'b101000,
        OpSh      = 6'b101001,
        OpSw      = 6'b101011
    } opcodeT;

    typedef enum logic [5:0] {
        FnSll     = 6'b000000,
        FnSrl     = 6'b000010,
        FnSra     = 6'b000011,
        FnSllv    = 6'b000100,
        FnSrlv    = 6'b000110,
        FnSrav    = 6'b000111,
        FnJr      = 6'b001000,
        FnJalr    = 6'b001001,
        FnSyscall = 6'b001100,
        FnBreak   = 6'b001101,
        FnMfhi    = 6'b010000,
        FnMthi    = 6'b010001,
        FnMflo    = 6'b010010,
        FnMtlo    = 6'b010011,
        FnMult    = 6'b011000,
        FnMultu   = 6'b011001,
        FnDiv     = 6'b011010,
        FnDivu    = 6'b011011,
        FnAdd     = 6'b100000,
        FnAddu    = 6'b100001,
        FnSub     = 6'b100010,
        FnSubu    = 6'b100011,
        FnAnd     = 6'b100100,
        FnOr      = 6'b100101,
        FnXor     = 6'b100110,
        FnNor     = 6'b100111,
        FnSlt     = 6'b101010,
        FnSltu    = 6'b101011
    } functT;

    typedef enum logic [2:0] {
        MemWord  = 3'd0,
        MemHalf  = 3'd1,
        MemHalfU = 3'd2,
        MemByte  = 3'd3,
        MemByteU = 3'd4
    } memOpT;

    typedef enum logic [4:0] {
        ExcNone = 5'd0,
        ExcAdel = 5'd4,
        ExcAdes = 5'd5,
        ExcSys  = 5'd8,
        ExcBp   = 5'd9,
        ExcRi   = 5'd10
    } excCodeT;

    // COP0 rs field forms
    localparam logic [4:0] Cop0Mf = 5'b00000;
    localparam logic [4:0] Cop0Mt = 5'b00100;
    localparam logic [4:0] Cop0Co = 5'b10000;
    localparam logic [5:0] FnEret = 6'b011000;  // Funct under the CO form

    ////////////////////////////////////////////////////////////////////////////
    // CP0 register map and constants
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [4:0]  Cp0BadVAddr  = 5'd8;
    localparam logic [4:0]  Cp0Status    = 5'd12;
    localparam logic [4:0]  Cp0Cause     = 5'd13;
    localparam logic [4:0]  Cp0Epc       = 5'd14;

    localparam logic [31:0] ExcVector    = 32'hBFC0_0380;
    localparam logic [31:0] StatusReset  = 32'h0040_0000;  // BEV only
    localparam logic [31:0] StatusWrMask = 32'h0000_FF03;  // IM, EXL, IE
    localparam int          StatusExl    = 1;
    localparam int          CauseBd      = 31;

    typedef struct packed {
        logic        valid;
        logic [31:0] instr;
        logic [31:0] pc;
        logic        inDelaySlot;
        logic [31:0] addr;
        logic [31:0] wdata;       // rt operand for MTC0
    } memInstrT;

    typedef struct packed {
        excCodeT    excCode;
        logic       isLoad;
        logic       isStore;
        memOpT      memOp;
        logic       isMfc0;
        logic       isMtc0;
        logic       isEret;
        logic [4:0] cp0Addr;
    } instrClassT;

    typedef struct packed {
        logic        excCommit;
        logic        eretCommit;
        logic        mtc0We;
        excCodeT     excCode;
        logic [31:0] pc;
        logic        inDelaySlot;
        logic [31:0] badVAddr;
        logic        badVAddrValid;
    } excEventT;

endpackage

`default_nettype wire

// ==== source/instrCheck.sv ====
`timescale 1ns/1ns
`default_nettype none

module instrCheck (
    input  wire logic [31:0]   instr_i,
    output excPkg::instrClassT class_o
);

    excPkg::opcodeT opcode;
    excPkg::functT  funct;
    logic [4:0]     rs;
    logic [4:0]     rt;
    logic [4:0]     rd;
    logic           legal;
    logic           isSyscall;
    logic           isBreak;
    logic           isMfc0;
    logic           isMtc0;
    logic           isEret;

    assign opcode = excPkg::opcodeT'(instr_i[31:26]);
    assign funct  = excPkg::functT'(instr_i[5:0]);
    assign rs     = instr_i[25:21];
    assign rt     = instr_i[20:16];
    assign rd     = instr_i[15:11];

    assign isSyscall = (opcode == excPkg::OpSpecial) && (funct == excPkg::FnSyscall);
    assign isBreak   = (opcode == excPkg::OpSpecial) && (funct == excPkg::FnBreak);

    // CP0 forms, the only legal ones under COP0
    assign isMfc0 = (opcode == excPkg::OpCop0) && (rs == excPkg::Cop0Mf);
    assign isMtc0 = (opcode == excPkg::OpCop0) && (rs == excPkg::Cop0Mt);
    assign isEret = (opcode == excPkg::OpCop0) && (rs == excPkg::Cop0Co)
                    && (instr_i[5:0] == excPkg::FnEret);

    assign class_o.isMfc0  = isMfc0;
    assign class_o.isMtc0  = isMtc0;
    assign class_o.isEret  = isEret;
    assign class_o.cp0Addr = rd;

    always_comb begin
        legal           = 1'b1;
        class_o.isLoad  = 1'b0;
        class_o.isStore = 1'b0;
        class_o.memOp   = excPkg::MemWord;
        case (opcode)
            excPkg::OpSpecial: begin
                case (funct)
                    excPkg::FnSll, excPkg::FnSrl, excPkg::FnSra,
                    excPkg::FnSllv, excPkg::FnSrlv, excPkg::FnSrav,
                    excPkg::FnJr, excPkg::FnJalr, excPkg::FnSyscall, excPkg::FnBreak,
                    excPkg::FnMfhi, excPkg::FnMthi, excPkg::FnMflo, excPkg::FnMtlo,
                    excPkg::FnMult, excPkg::FnMultu, excPkg::FnDiv, excPkg::FnDivu,
                    excPkg::FnAdd, excPkg::FnAddu, excPkg::FnSub, excPkg::FnSubu,
                    excPkg::FnAnd, excPkg::FnOr, excPkg::FnXor, excPkg::FnNor,
                    excPkg::FnSlt, excPkg::FnSltu:
                        legal = 1'b1;
                    default:
                        legal = 1'b0;
                endcase
            end
            excPkg::OpRegimm: legal = rt inside {5'd0, 5'd1, 5'd16, 5'd17};  // BLTZ..BGEZAL
            excPkg::OpCop0:   legal = isMfc0 || isMtc0 || isEret;
            excPkg::OpLw: begin
                class_o.isLoad = 1'b1;
            end
            excPkg::OpLh: begin
                class_o.isLoad = 1'b1;
                class_o.memOp  = excPkg::MemHalf;
            end
            excPkg::OpLhu: begin
                class_o.isLoad = 1'b1;
                class_o.memOp  = excPkg::MemHalfU;
            end
            excPkg::OpLb: begin
                class_o.isLoad = 1'b1;
                class_o.memOp  = excPkg::MemByte;
            end
            excPkg::OpLbu: begin
                class_o.isLoad = 1'b1;
                class_o.memOp  = excPkg::MemByteU;
            end
            excPkg::OpSw: begin
                class_o.isStore = 1'b1;
            end
            excPkg::OpSh: begin
                class_o.isStore = 1'b1;
                class_o.memOp   = excPkg::MemHalf;
            end
            excPkg::OpSb: begin
                class_o.isStore = 1'b1;
                class_o.memOp   = excPkg::MemByte;
            end
            excPkg::OpJ, excPkg::OpJal, excPkg::OpBeq, excPkg::OpBne,
            excPkg::OpBlez, excPkg::OpBgtz, excPkg::OpAddi, excPkg::OpAddiu,
            excPkg::OpSlti, excPkg::OpSltiu, excPkg::OpAndi, excPkg::OpOri,
            excPkg::OpXori, excPkg::OpLui:
                legal = 1'b1;
            default:
                legal = 1'b0;
        endcase
    end

    // Trap codes outrank reserved instruction
    assign class_o.excCode = isSyscall ? excPkg::ExcSys :
                             isBreak   ? excPkg::ExcBp  :
                             !legal    ? excPkg::ExcRi  :
                                         excPkg::ExcNone;

endmodule

`default_nettype wire

// ==== source/excCommit.sv ====
`timescale 1ns/1ns
`default_nettype none

module excCommit (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire excPkg::memInstrT   memInstr_i,
    input  wire excPkg::instrClassT class_i,
    input  wire logic [31:0]        epc_i,
    output excPkg::excEventT        event_o,
    output logic                    redirect_o,
    output logic [31:0]             redirectPc_o,
    output logic                    squash_o
);

    logic            squashQ;
    logic            live;
    logic            wordMis;
    logic            halfMis;
    logic            addrErr;
    logic            excCommit;
    logic            eretCommit;
    excPkg::excCodeT addrCode;
    excPkg::excCodeT finalCode;

    assign live = memInstr_i.valid && !squashQ;  // Younger one after a commit is dead

    ////////////////////////////////////////////////////////////////////////////
    // Address alignment
    ////////////////////////////////////////////////////////////////////////////

    assign wordMis = (class_i.memOp == excPkg::MemWord) && (memInstr_i.addr[1:0] != 2'b00);
    assign halfMis = ((class_i.memOp == excPkg::MemHalf) || (class_i.memOp == excPkg::MemHalfU))
                     && memInstr_i.addr[0];
    assign addrErr = live && (class_i.isLoad || class_i.isStore) && (wordMis || halfMis);
    assign addrCode = class_i.isLoad ? excPkg::ExcAdel : excPkg::ExcAdes;

    ////////////////////////////////////////////////////////////////////////////
    // Priority and commit
    ////////////////////////////////////////////////////////////////////////////

    assign finalCode  = !live   ? excPkg::ExcNone :
                        addrErr ? addrCode        :
                                  class_i.excCode;
    assign excCommit  = (finalCode != excPkg::ExcNone);
    assign eretCommit = live && class_i.isEret && !excCommit;

    always_comb begin
        event_o.excCommit     = excCommit;
        event_o.eretCommit    = eretCommit;
        event_o.mtc0We        = live && class_i.isMtc0 && !excCommit && !eretCommit;
        event_o.excCode       = finalCode;
        event_o.pc            = memInstr_i.pc;
        event_o.inDelaySlot   = memInstr_i.inDelaySlot;
        event_o.badVAddr      = memInstr_i.addr;
        event_o.badVAddrValid = addrErr;
    end

    assign redirect_o   = excCommit || eretCommit;
    assign redirectPc_o = excCommit ? excPkg::ExcVector : epc_i;  // ERET returns to EPC

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            squashQ <= 1'b0;
        end else begin
            squashQ <= redirect_o;
        end
    end

    assign squash_o = squashQ;

    // AdEL or AdES needs a record that is a load or a store, never both
    classLoadStore: assert property (@(posedge clk) disable iff (rst)
        !(class_i.isLoad && class_i.isStore));

endmodule

`default_nettype wire

// ==== source/cp0Regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module cp0Regs (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire excPkg::excEventT event_i,
    input  wire logic [4:0]       waddr_i,
    input  wire logic [31:0]      wdata_i,
    input  wire logic [4:0]       raddr_i,
    output logic [31:0]           rdata_o,
    output logic [31:0]           epc_o,
    output logic [31:0]           status_o,
    output logic [31:0]           cause_o
);

    logic [31:0] badVAddrQ;
    logic [31:0] statusQ;
    logic [31:0] causeQ;
    logic [31:0] epcQ;
    logic [31:0] badVAddrNext;
    logic [31:0] statusNext;
    logic [31:0] causeNext;
    logic [31:0] epcNext;
    logic        bypass;

    function automatic logic [31:0] regSelect(
        input logic [4:0]  addr,
        input logic [31:0] badVAddr,
        input logic [31:0] status,
        input logic [31:0] cause,
        input logic [31:0] epc
    );
        case (addr)
            excPkg::Cp0BadVAddr: return badVAddr;
            excPkg::Cp0Status:   return status;
            excPkg::Cp0Cause:    return cause;
            excPkg::Cp0Epc:      return epc;
            default:             return 32'h0;  // Unimplemented read as zero
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Next state
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        badVAddrNext = badVAddrQ;
        statusNext   = statusQ;
        causeNext    = causeQ;
        epcNext      = epcQ;
        if (event_i.excCommit) begin
            statusNext[excPkg::StatusExl] = 1'b1;
            causeNext[excPkg::CauseBd]    = event_i.inDelaySlot;
            causeNext[6:2]                = event_i.excCode;
            // Delay slot faults restart at the branch
            epcNext = event_i.inDelaySlot ? event_i.pc - 32'd4 : event_i.pc;
            if (event_i.badVAddrValid) begin
                badVAddrNext = event_i.badVAddr;
            end
        end else if (event_i.eretCommit) begin
            statusNext[excPkg::StatusExl] = 1'b0;
        end else if (event_i.mtc0We) begin
            case (waddr_i)
                excPkg::Cp0Status: statusNext = (statusQ & ~excPkg::StatusWrMask)
                                                | (wdata_i & excPkg::StatusWrMask);
                excPkg::Cp0Epc:    epcNext = wdata_i;
                default: ;                      // Cause and BadVAddr are read only
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            badVAddrQ <= 32'h0;
            statusQ   <= excPkg::StatusReset;
            causeQ    <= 32'h0;
            epcQ      <= 32'h0;
        end else begin
            badVAddrQ <= badVAddrNext;
            statusQ   <= statusNext;
            causeQ    <= causeNext;
            epcQ      <= epcNext;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read port
    ////////////////////////////////////////////////////////////////////////////

    // MFC0 sees an MTC0 to the same register in this cycle
    assign bypass = event_i.mtc0We && (waddr_i == raddr_i);

    assign rdata_o = bypass ? regSelect(raddr_i, badVAddrNext, statusNext, causeNext, epcNext)
                            : regSelect(raddr_i, badVAddrQ, statusQ, causeQ, epcQ);

    assign epc_o    = epcQ;
    assign status_o = statusQ;
    assign cause_o  = causeQ;

    // Exception entry never shares a cycle with ERET or an MTC0 write
    eventExclusive: assert property (@(posedge clk) disable iff (rst)
        $onehot0({event_i.excCommit, event_i.eretCommit, event_i.mtc0We}));

endmodule

`default_nettype wire

// ==== source/excUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module excUnit (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire excPkg::memInstrT memInstr_i,
    input  wire logic [4:0]       cp0Raddr_i,
    output logic                  excCommit_o,
    output logic                  eretCommit_o,
    output logic                  redirect_o,
    output logic [31:0]           redirectPc_o,
    output logic                  squash_o,
    output excPkg::excCodeT       excCode_o,
    output logic [31:0]           cp0Rdata_o,
    output logic [31:0]           epc_o,
    output logic [31:0]           status_o,
    output logic [31:0]           cause_o
);

    excPkg::instrClassT instrClass;
    excPkg::excEventT   excEvent;

    instrCheck i_instrCheck (
        .instr_i (memInstr_i.instr),
        .class_o (instrClass)
    );

    excCommit i_excCommit (
        .clk          (clk),
        .rst          (rst),
        .memInstr_i   (memInstr_i),
        .class_i      (instrClass),
        .epc_i        (epc_o),          // ERET target as it stands now
        .event_o      (excEvent),
        .redirect_o   (redirect_o),
        .redirectPc_o (redirectPc_o),
        .squash_o     (squash_o)
    );

    cp0Regs i_cp0Regs (
        .clk      (clk),
        .rst      (rst),
        .event_i  (excEvent),
        .waddr_i  (instrClass.cp0Addr),
        .wdata_i  (memInstr_i.wdata),
        .raddr_i  (cp0Raddr_i),
        .rdata_o  (cp0Rdata_o),
        .epc_o    (epc_o),
        .status_o (status_o),
        .cause_o  (cause_o)
    );

    assign excCommit_o  = excEvent.excCommit;
    assign eretCommit_o = excEvent.eretCommit;
    assign excCode_o    = excEvent.excCode;

endmodule

`default_nettype wire

// ==== include/excTbTable.svh ====
`ifndef EXC_TB_TABLE_SVH
`define EXC_TB_TABLE_SVH

    task automatic loadRows();
        // instr, pc, inDelaySlot, addr, wdata, cp0Raddr,
        // expected exception code, eretCommit, redirect target, squash, CP0 check, CP0 value

        ////////////////////////////////////////////////////////////////////////////
        // Decode exceptions, each followed by its squash row
        ////////////////////////////////////////////////////////////////////////////
        addRow('h00221821, 'h100, 0, 'h0, 'h0, 0, 0, 0, 'h0, 0, SelStatus, 'h00400000);
        addRow('h0000000C, 'h104, 0, 'h0, 'h0, 0, 8, 0, Vec, 0, SelCause, 'h0);
        addRow('h00000000, 'h108, 0, 'h0, 'h0, 0, 0, 0, 'h0, 1, SelCause, 'h20);
        addRow('h0000000D, 'h10C, 0, 'h0, 'h0, 0, 9, 0, Vec, 0, SelEpc, 'h104);
        addRow('h00000000, 'h110, 0, 'h0, 'h0, 0, 0, 0, 'h0, 1, SelCause, 'h24);
        addRow('h00000001, 'h114, 0, 'h0, 'h0, 0, 10, 0, Vec, 0, SelEpc, 'h10C);  // Bad funct
        addRow('h00000000, 'h118, 0, 'h0, 'h0, 0, 0, 0, 'h0, 1, SelCause, 'h28);
        addRow('h40400000, 'h11C, 0, 'h0, 'h0, 0, 10, 0, Vec, 0, SelStatus, 'h00400002);
        // SYSCALL in the squash slot must not commit
        addRow('h0000000C, 'h120, 0, 'h0, 'h0, 0, 0, 0, 'h0, 1, SelCause, 'h28);
        addRow('h00000000, 'h124, 0, 'h0, 'h0, 0, 0, 0, 'h0, 0, SelEpc, 'h11C);

        ////////////////////////////////////////////////////////////////////////////
        // Address errors, BadVAddr read back through the read port
        ////////////////////////////////////////////////////////////////////////////
        addRow('h8C220000, 'h128, 0, 'h1002, 'h0, 0, 4, 0, Vec, 0, SelCause, 'h28);
        addRow('h00000000, 'h12C, 0, 'h0, 'h0, 8, 0, 0, 'h0, 1, SelRdata, 'h1002);
        addRow('h84220000, 'h130, 0, 'h2001, 'h0, 0, 4, 0, Vec, 0, SelCause, 'h10);
        addRow('h00000000, 'h134, 0, 'h0, 'h0, 8, 0, 0, 'h0, 1, SelRdata, 'h2001);
        addRow('hAC220000, 'h138, 0, 'h3003, 'h0, 0, 5, 0, Vec, 0, SelCause, 'h10);
        addRow('h00000000, 'h13C, 0, 'h0, 'h0, 8, 0, 0, 'h0, 1, SelRdata, 'h3003);
        addRow('hA4220000, 'h140, 0, 'h4003, 'h0, 0, 5, 0, Vec, 0, SelCause, 'h14);
        addRow('h00000000, 'h144, 0, 'h0, 'h0, 8, 0, 0, 'h0, 1, SelRdata, 'h4003);
        addRow('h8C220000, 'h148, 0, 'h5004, 'h0, 0, 0, 0, 'h0, 0, SelEpc, 'h140);
        addRow('h80220000, 'h14C, 0, 'h5003, 'h0, 0, 0, 0, 'h0, 0, SelCause, 'h14);
        addRow('hA0220000, 'h150, 0, 'h6001, 'h0, 8, 0, 0, 'h0, 0, SelRdata, 'h4003);

        ////////////////////////////////////////////////////////////////////////////
        // Delay slot, ERET and MTC0
        ////////////////////////////////////////////////////////////////////////////
        addRow('h0000000C, 'h200, 1, 'h0, 'h0, 0, 8, 0, Vec, 0, SelStatus, 'h00400002);
        addRow('h00000000, 'h204, 0, 'h0, 'h0, 0, 0, 0, 'h0, 1, SelEpc, 'h1FC);
        addRow('h0000000D, 'h300, 0, 'h0, 'h0, 0, 9, 0, Vec, 0, SelCause, 'h80000020);
        addRow('h00000000, 'h304, 0, 'h0, 'h0, 0, 0, 0, 'h0, 1, SelCause, 'h24);
        addRow('h42000018, 'h308, 0, 'h0, 'h0, 0, 0, 1, 'h300, 0, SelStatus, 'h00400002);
        addRow('h00000000, 'h30C, 0, 'h0, 'h0, 0, 0, 0, 'h0, 1, SelStatus, 'h00400000);
        addRow('h40827000, 'h310, 0, 'h0, 'hABCD0000, 14, 0, 0, 'h0, 0, SelRdata, 'hABCD0000);
        addRow('h00000000, 'h314, 0, 'h0, 'h0, 0, 0, 0, 'h0, 0, SelEpc, 'hABCD0000);
        addRow('h40826000, 'h318, 0, 'h0, 'hFFFFFFFF, 12, 0, 0, 'h0, 0, SelRdata, 'h0040FF03);
        addRow('h00000000, 'h31C, 0, 'h0, 'h0, 0, 0, 0, 'h0, 0, SelStatus, 'h0040FF03);
        addRow('h40826800, 'h320, 0, 'h0, 'hFFFFFFFF, 13, 0, 0, 'h0, 0, SelRdata, 'h24);
        addRow('h00000000, 'h324, 0, 'h0, 'h0, 0, 0, 0, 'h0, 0, SelCause, 'h24);
        // MTC0 in the squash slot is dropped
        addRow('h0000000C, 'h400, 0, 'h0, 'h0, 0, 8, 0, Vec, 0, SelStatus, 'h0040FF03);
        addRow('h40827000, 'h404, 0, 'h0, 'h12345678, 14, 0, 0, 'h0, 1, SelRdata, 'h400);
        addRow('h42000018, 'h408, 0, 'h0, 'h0, 0, 0, 1, 'h400, 0, SelCause, 'h20);
        addRow('h00000000, 'h40C, 0, 'h0, 'h0, 0, 0, 0, 'h0, 1, SelStatus, 'h0040FF01);
    endtask

`endif

// ==== tb/excUnitTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module excUnitTb;

    localparam logic [31:0] Vec         = 32'hBFC0_0380;  // Exception vector
    localparam int          CycleMargin = 20;

    typedef enum logic [2:0] {
        SelNone,
        SelRdata,
        SelEpc,
        SelStatus,
        SelCause
    } chkSelT;

    typedef struct packed {
        excPkg::memInstrT rec;
        logic [4:0]       raddr;
        logic [4:0]       expCode;    // Zero when no exception commits
        logic             expEret;
        logic [31:0]      expPc;      // Only meaningful on a redirect
        logic             expSquash;
        chkSelT           sel;
        logic [31:0]      expVal;
    } rowT;

    logic             clk;
    logic             rst;
    excPkg::memInstrT memInstr;
    logic [4:0]       cp0Raddr;
    logic             excPulse;
    logic             eretPulse;
    logic             redirect;
    logic [31:0]      redirectPc;
    logic             squash;
    excPkg::excCodeT  excCode;
    logic [31:0]      cp0Rdata;
    logic [31:0]      epc;
    logic [31:0]      status;
    logic [31:0]      cause;

    rowT rows[$];
    int  errors;
    int  failedRows;
    int  cycles;
    int  cycleLimit;

    excUnit i_dut (
        .clk          (clk),
        .rst          (rst),
        .memInstr_i   (memInstr),
        .cp0Raddr_i   (cp0Raddr),
        .excCommit_o  (excPulse),
        .eretCommit_o (eretPulse),
        .redirect_o   (redirect),
        .redirectPc_o (redirectPc),
        .squash_o     (squash),
        .excCode_o    (excCode),
        .cp0Rdata_o   (cp0Rdata),
        .epc_o        (epc),
        .status_o     (status),
        .cause_o      (cause)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic addRow(input logic [31:0] instr, input logic [31:0] pc, input int ds,
                          input logic [31:0] addr, input logic [31:0] wdata, input int raddr,
                          input int expCode, input int expEret, input logic [31:0] expPc,
                          input int expSquash, input chkSelT sel, input logic [31:0] expVal);
        rowT r;
        r.rec.valid       = 1'b1;
        r.rec.instr       = instr;
        r.rec.pc          = pc;
        r.rec.inDelaySlot = (ds != 0);
        r.rec.addr        = addr;
        r.rec.wdata       = wdata;
        r.raddr           = raddr[4:0];
        r.expCode         = expCode[4:0];
        r.expEret         = (expEret != 0);
        r.expPc           = expPc;
        r.expSquash       = (expSquash != 0);
        r.sel             = sel;
        r.expVal          = expVal;
        rows.push_back(r);
    endtask

    `include "excTbTable.svh"

    ////////////////////////////////////////////////////////////////////////////
    // Checking
    ////////////////////////////////////////////////////////////////////////////

    function automatic string selName(input chkSelT sel);
        case (sel)
            SelRdata:  return "cp0Rdata_o";
            SelEpc:    return "epc_o";
            SelStatus: return "status_o";
            SelCause:  return "cause_o";
            default:   return "none";
        endcase
    endfunction

    function automatic logic [31:0] selectedCp0(input chkSelT sel);
        case (sel)
            SelRdata:  return cp0Rdata;
            SelEpc:    return epc;
            SelStatus: return status;
            SelCause:  return cause;
            default:   return 32'h0;
        endcase
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp)
            else begin
                $display("FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
                errors++;
            end
    endtask

    task automatic checkRow(input rowT r);
        logic expExc;
        logic expRedirect;
        expExc      = (r.expCode != 5'd0);     // Any nonzero code commits
        expRedirect = expExc || r.expEret;     // Either commit redirects
        checkValue("excCommit_o", 32'(excPulse), 32'(expExc));
        checkValue("excCode_o", 32'(excCode), 32'(r.expCode));
        checkValue("eretCommit_o", 32'(eretPulse), 32'(r.expEret));
        checkValue("redirect_o", 32'(redirect), 32'(expRedirect));
        if (expRedirect) begin
            checkValue("redirectPc_o", redirectPc, r.expPc);
        end
        checkValue("squash_o", 32'(squash), 32'(r.expSquash));
        if (r.sel != SelNone) begin
            checkValue(selName(r.sel), selectedCp0(r.sel), r.expVal);
        end
    endtask

    // Run limit from the table length
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycleLimit) begin
            $display("Timeout: run exceeded %0d cycles", cycleLimit);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        int mark;
        rst        = 1'b1;
        memInstr   = '0;
        cp0Raddr   = 5'd0;
        errors     = 0;
        failedRows = 0;
        cycles     = 0;
        loadRows();
        cycleLimit = rows.size() + CycleMargin;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < rows.size(); i++) begin
            mark     = errors;
            memInstr = rows[i].rec;
            cp0Raddr = rows[i].raddr;
            #2;                                 // Settle, well before the next edge
            checkRow(rows[i]);
            if (errors == mark) begin
                $display("Row %0d pc=%h: ok", i, rows[i].rec.pc);
            end else begin
                $display("Row %0d pc=%h: %0d mismatches", i, rows[i].rec.pc, errors - mark);
                failedRows++;
            end
            @(negedge clk);
        end
        $display("Rows: %0d, failed rows: %0d, mismatches: %0d",
                 rows.size(), failedRows, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+include
source/excPkg.sv
source/instrCheck.sv
source/excCommit.sv
source/cp0Regs.sv
source/excUnit.sv
tb/excUnitTb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and pass only if the pass message shows up
verilator --binary --timing --assert -f list.f --top-module excUnitTb -o excUnitSim \
    && ./obj_dir/excUnitSim | tee /dev/stderr | grep "ALL CHECKS PASSED" > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
